// File: core_pkg.sv
package core_pkg;

    // Data, address and pc values
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // ALU operation select
    typedef logic [1:0] alu_op_t;
    localparam alu_op_t ALU_ADD   = 2'd0;
    localparam alu_op_t ALU_SUB   = 2'd1;
    localparam alu_op_t ALU_PASSB = 2'd2;

    // Writeback source select
    typedef logic [1:0] wb_sel_t;
    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    // Next pc choice
    typedef logic pc_sel_t;
    localparam pc_sel_t PC_SEQ    = 1'b0;
    localparam pc_sel_t PC_TARGET = 1'b1;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // One-cycle phases of every instruction
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        WB
    } phase_e;

    localparam word_t RESET_PC = 32'h0;

endpackage

// File: core_regfile.sv
`timescale 1ns/1ns

module core_regfile import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  logic      we_i
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: core_ifu.sv
`timescale 1ns/1ns

module core_ifu import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  phase_e phase_i,
    input  logic   take_target_i,
    input  word_t  target_i,
    output word_t  pc_o,
    output word_t  pc_plus4_o
);

    word_t   pc_q;
    word_t   pc_next;
    pc_sel_t pc_sel;

    assign pc_plus4_o = pc_q + 32'd4;
    assign pc_sel     = take_target_i ? PC_TARGET : PC_SEQ;

    always_comb begin
        if (pc_sel == PC_TARGET) begin
            pc_next = target_i;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    // Pc holds for the whole instruction and moves on at the end of WB
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (phase_i == WB) begin
            pc_q <= pc_next;
        end
    end

    // Also used as the instruction fetch address
    assign pc_o = pc_q;

endmodule

// File: core_idu.sv
`timescale 1ns/1ns

module core_idu import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  phase_e    phase_i,
    input  inst_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output word_t     op_a_o,
    output word_t     op_b_o,
    output word_t     store_data_o,
    output word_t     target_o,
    output alu_op_t   alu_op_o,
    output logic      is_branch_o,
    output logic      branch_ne_o,
    output logic      is_store_o,
    output logic      is_jal_o,
    output logic      is_halt_o,
    output reg_addr_t rd_addr_o,
    output logic      rd_we_o,
    output wb_sel_t   wb_sel_o
);

    inst_t   inst_q;
    word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t   op_b_d, tgt_imm_d;
    alu_op_t alu_op_d;
    wb_sel_t wb_sel_d;
    logic    rd_we_d, is_branch_d, is_store_d, is_jal_d, is_halt_d;

    // Register reads straight from the fetched word during DECODE
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        op_b_d      = rs2_data_i;
        tgt_imm_d   = imm_b;
        alu_op_d    = ALU_ADD;
        wb_sel_d    = WB_ALU;
        rd_we_d     = 1'b0;
        is_branch_d = 1'b0;
        is_store_d  = 1'b0;
        is_jal_d    = 1'b0;
        is_halt_d   = 1'b0;
        case (inst_i[6:0])
            OPC_OP:     begin rd_we_d = 1'b1; alu_op_d = inst_i[30] ? ALU_SUB : ALU_ADD; end
            OPC_OP_IMM: begin rd_we_d = 1'b1; op_b_d = imm_i; end
            OPC_LUI:    begin rd_we_d = 1'b1; op_b_d = imm_u; alu_op_d = ALU_PASSB; end
            OPC_LOAD:   begin rd_we_d = 1'b1; op_b_d = imm_i; wb_sel_d = WB_MEM; end
            OPC_STORE:  begin is_store_d = 1'b1; op_b_d = imm_s; end
            OPC_BRANCH: is_branch_d = 1'b1;
            OPC_JAL:    begin rd_we_d = 1'b1; is_jal_d = 1'b1; wb_sel_d = WB_PC4; tgt_imm_d = imm_j; end
            // EBREAK only, other SYSTEM encodings fall through as no-ops
            OPC_SYSTEM: is_halt_d = (inst_i[31:7] == 25'h0002000);
            default:    ;
        endcase
    end

    // Operands and target are payload
    always_ff @(posedge clk) begin
        if (phase_i == DECODE) begin
            inst_q       <= inst_i;
            op_a_o       <= rs1_data_i;
            op_b_o       <= op_b_d;
            store_data_o <= rs2_data_i;
            target_o     <= pc_i + tgt_imm_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_op_o    <= ALU_ADD;
            wb_sel_o    <= WB_ALU;
            rd_we_o     <= 1'b0;
            is_branch_o <= 1'b0;
            branch_ne_o <= 1'b0;
            is_store_o  <= 1'b0;
            is_jal_o    <= 1'b0;
            is_halt_o   <= 1'b0;
        end else if (phase_i == DECODE) begin
            alu_op_o    <= alu_op_d;
            wb_sel_o    <= wb_sel_d;
            rd_we_o     <= rd_we_d;
            is_branch_o <= is_branch_d;
            // funct3 bit 0 separates BNE from BEQ
            branch_ne_o <= inst_i[12];
            is_store_o  <= is_store_d;
            is_jal_o    <= is_jal_d;
            is_halt_o   <= is_halt_d;
        end
    end

    assign rd_addr_o = inst_q[11:7];

endmodule

// File: core_exu.sv
`timescale 1ns/1ns

module core_exu import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  phase_e  phase_i,
    input  word_t   op_a_i,
    input  word_t   op_b_i,
    input  word_t   store_data_i,
    input  alu_op_t alu_op_i,
    input  logic    is_branch_i,
    input  logic    branch_ne_i,
    input  logic    is_store_i,
    input  logic    is_jal_i,
    output word_t   result_o,
    output logic    take_target_o,
    output word_t   dmem_addr_o,
    output word_t   dmem_wdata_o,
    output logic    dmem_we_o
);

    word_t alu_out;
    word_t result_q;
    logic  ops_equal;
    logic  take_d;
    logic  take_q;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:   alu_out = op_a_i - op_b_i;
            ALU_PASSB: alu_out = op_b_i;
            default:   alu_out = op_a_i + op_b_i;
        endcase
    end

    // BEQ on equal, BNE on not equal, JAL always
    assign ops_equal = (op_a_i == op_b_i);
    assign take_d    = is_jal_i | (is_branch_i & (ops_equal ^ branch_ne_i));

    always_ff @(posedge clk) begin
        if (phase_i == EXEC) begin
            result_q <= alu_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            take_q <= 1'b0;
        end else if (phase_i == EXEC) begin
            take_q <= take_d;
        end
    end

    assign result_o      = result_q;
    assign take_target_o = take_q;

    // Data port, the write strobe only in MEM
    assign dmem_addr_o  = result_q;
    assign dmem_wdata_o = store_data_i;
    assign dmem_we_o    = (phase_i == MEM) && is_store_i;

endmodule

// File: core_wbu.sv
`timescale 1ns/1ns

module core_wbu import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      is_halt_i,
    input  logic      rd_we_i,
    input  reg_addr_t rd_addr_i,
    input  wb_sel_t   wb_sel_i,
    input  word_t     alu_result_i,
    input  word_t     mem_rdata_i,
    input  word_t     pc_i,
    input  word_t     pc_plus4_i,
    output phase_e    phase_o,
    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o,
    output word_t     rf_wdata_o,
    output logic      retire_o,
    output word_t     retire_pc_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o,
    output logic      halted_o
);

    phase_e phase_q, phase_d;
    logic   halted_q;
    logic   has_write;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            // Parked here for good once halted
            FETCH:   phase_d = halted_q ? FETCH : DECODE;
            DECODE:  phase_d = EXEC;
            EXEC:    phase_d = MEM;
            MEM:     phase_d = WB;
            WB:      phase_d = FETCH;
            default: phase_d = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            phase_q  <= FETCH;
            halted_q <= 1'b0;
        end else begin
            phase_q <= phase_d;
            if (phase_q == WB && is_halt_i) begin
                halted_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  rf_wdata_o = mem_rdata_i;
            WB_PC4:  rf_wdata_o = pc_plus4_i;
            default: rf_wdata_o = alu_result_i;
        endcase
    end

    // A write to x0 counts as no write
    assign has_write  = rd_we_i && (rd_addr_i != '0);
    assign rf_we_o    = (phase_q == WB) && has_write;
    assign rf_waddr_o = rd_addr_i;

    assign retire_o      = (phase_q == WB);
    assign retire_pc_o   = pc_i;
    assign retire_rd_o   = has_write ? rd_addr_i : '0;
    assign retire_data_o = has_write ? rf_wdata_o : '0;

    assign phase_o  = phase_q;
    assign halted_o = halted_q;

endmodule

// File: core_top.sv
`timescale 1ns/1ns

module core_top import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    output word_t     imem_addr_o,
    input  inst_t     imem_data_i,
    output word_t     dmem_addr_o,
    output word_t     dmem_wdata_o,
    output logic      dmem_we_o,
    input  word_t     dmem_rdata_i,
    output logic      retire_o,
    output word_t     retire_pc_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o,
    output logic      halted_o
);

    phase_e    phase;
    word_t     pc, pc_plus4, target, alu_result;
    word_t     rs1_data, rs2_data, op_a, op_b, store_data, rf_wdata;
    reg_addr_t rs1_addr, rs2_addr, rd_addr, rf_waddr;
    alu_op_t   alu_op;
    wb_sel_t   wb_sel;
    logic      take_target, rd_we, rf_we;
    logic      is_branch, branch_ne, is_store, is_jal, is_halt;

    assign imem_addr_o = pc;

    core_regfile u_regfile (
        .clk(clk), .rst_n_i(rst_n_i),
        .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data),
        .waddr_i(rf_waddr), .wdata_i(rf_wdata), .we_i(rf_we)
    );

    core_ifu u_ifu (
        .clk(clk), .rst_n_i(rst_n_i), .phase_i(phase),
        .take_target_i(take_target), .target_i(target),
        .pc_o(pc), .pc_plus4_o(pc_plus4)
    );

    core_idu u_idu (
        .clk(clk), .rst_n_i(rst_n_i), .phase_i(phase),
        .inst_i(imem_data_i), .pc_i(pc),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .op_a_o(op_a), .op_b_o(op_b), .store_data_o(store_data), .target_o(target),
        .alu_op_o(alu_op), .is_branch_o(is_branch), .branch_ne_o(branch_ne),
        .is_store_o(is_store), .is_jal_o(is_jal), .is_halt_o(is_halt),
        .rd_addr_o(rd_addr), .rd_we_o(rd_we), .wb_sel_o(wb_sel)
    );

    core_exu u_exu (
        .clk(clk), .rst_n_i(rst_n_i), .phase_i(phase),
        .op_a_i(op_a), .op_b_i(op_b), .store_data_i(store_data), .alu_op_i(alu_op),
        .is_branch_i(is_branch), .branch_ne_i(branch_ne),
        .is_store_i(is_store), .is_jal_i(is_jal),
        .result_o(alu_result), .take_target_o(take_target),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_we_o(dmem_we_o)
    );

    // Sequencer and writeback
    core_wbu u_wbu (
        .clk(clk), .rst_n_i(rst_n_i),
        .is_halt_i(is_halt), .rd_we_i(rd_we), .rd_addr_i(rd_addr), .wb_sel_i(wb_sel),
        .alu_result_i(alu_result), .mem_rdata_i(dmem_rdata_i),
        .pc_i(pc), .pc_plus4_i(pc_plus4), .phase_o(phase),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .retire_o(retire_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o),
        .halted_o(halted_o)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// File: tb_core_assert.sv
`timescale 1ns/1ns

module tb_core_assert (
    input logic clk,
    input logic rst_n_i,
    input logic dmem_we_o,
    input logic retire_o,
    input logic halted_o
);

    // At most one store strobe per instruction
    a_we_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_we_o |=> !dmem_we_o)
    else $error("dmem_we_o high in two consecutive cycles");

    // Retirements five cycles apart, so the four cycles before one are idle
    a_retire_gap: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_o |-> !$past(retire_o, 1) && !$past(retire_o, 2)
                  && !$past(retire_o, 3) && !$past(retire_o, 4))
    else $error("retire_o not followed by four idle cycles");

    // A halted core retires nothing
    a_no_retire_halted: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_o |-> !retire_o)
    else $error("retire_o seen while halted_o is high");

endmodule

// File: tb_core.sv
`timescale 1ns/1ns

module tb_core import core_pkg::*; ();

    localparam int          NUM_INSTS    = 200;
    localparam int          RESET_CYCLES = 3;
    // 201 instructions at 5 cycles each plus margin
    localparam int          MAX_CYCLES   = 1300;
    localparam logic [31:0] SEED         = 32'h67283588;
    localparam inst_t       EBREAK       = 32'h00100073;

    // Instruction kinds of the generated program
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_ADDI = 2;
    localparam int K_LUI  = 3;
    localparam int K_LW   = 4;
    localparam int K_SW   = 5;
    localparam int K_BEQ  = 6;
    localparam int K_BNE  = 7;
    localparam int K_JAL  = 8;
    localparam int K_HALT = 9;

    logic      clk;
    logic      rst_n;
    word_t     imem_addr, dmem_addr, dmem_wdata;
    inst_t     imem_data = '0;
    word_t     dmem_rdata = '0;
    logic      dmem_we, retire, halted;
    word_t     retire_pc, retire_data;
    reg_addr_t retire_rd;

    inst_t     imem [0:255];
    word_t     dmem [0:63];

    // Program fields as generated for the reference model
    int        kind [0:NUM_INSTS];
    reg_addr_t f_rd [0:NUM_INSTS];
    reg_addr_t f_rs1 [0:NUM_INSTS];
    reg_addr_t f_rs2 [0:NUM_INSTS];
    word_t     f_imm [0:NUM_INSTS];

    word_t     mdl_rf [0:31];
    word_t     mdl_mem [0:63];
    word_t     exp_pc [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    word_t     exp_st_addr [$];
    word_t     exp_st_data [$];

    logic [31:0] rng_state;
    int          cycle_cnt = 0;
    int          retire_cnt = 0;
    int          last_retire = 0;
    int          model_count = 0;

    tb_clk_gen u_clk_gen (.clk_o(clk));

    core_top dut (
        .clk(clk), .rst_n_i(rst_n),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_we_o(dmem_we),
        .dmem_rdata_i(dmem_rdata),
        .retire_o(retire), .retire_pc_o(retire_pc), .retire_rd_o(retire_rd),
        .retire_data_o(retire_data), .halted_o(halted)
    );

    bind core_top tb_core_assert u_assert (
        .clk(clk), .rst_n_i(rst_n_i), .dmem_we_o(dmem_we_o),
        .retire_o(retire_o), .halted_o(halted_o)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Low LCG bits repeat quickly so only upper bits are used
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:16]) % n;
    endfunction

    function automatic word_t fill_word(input int idx);
        return 32'hc0de0000 + word_t'(idx * 4);
    endfunction

    // Forward jump distance in words that never passes the final EBREAK
    function automatic int fwd_words(input int idx);
        int off;
        off = 1 + rand_below(4);
        if (idx + off > NUM_INSTS) begin
            off = NUM_INSTS - idx;
        end
        return off;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic build_program();
        int        sel;
        reg_addr_t rd, rs1, rs2;
        word_t     imm;
        inst_t     enc;
        // Unused words hold addi x0, x0 with the word index as immediate
        for (int i = 0; i < 256; i++) begin
            imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011};
        end
        for (int i = 0; i < NUM_INSTS; i++) begin
            sel = rand_below(9);
            rd  = reg_addr_t'(rand_below(8));
            rs1 = reg_addr_t'(rand_below(8));
            rs2 = reg_addr_t'(rand_below(8));
            imm = '0;
            case (sel)
                K_ADD, K_SUB: begin
                    enc = {(sel == K_SUB) ? 7'h20 : 7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
                end
                K_ADDI: begin
                    imm = next_rand();
                    imm = {{20{imm[11]}}, imm[11:0]};
                    enc = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
                end
                K_LUI: begin
                    imm = next_rand() & 32'hfffff000;
                    enc = {imm[31:12], rd, 7'b0110111};
                end
                K_LW, K_SW: begin
                    rs1 = '0;
                    imm = word_t'(rand_below(64) * 4);
                    if (sel == K_LW) begin
                        enc = {imm[11:0], 5'd0, 3'b010, rd, 7'b0000011};
                    end else begin
                        enc = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
                    end
                end
                K_BEQ, K_BNE: begin
                    imm = word_t'(fwd_words(i) * 4);
                    enc = {imm[12], imm[10:5], rs2, rs1, (sel == K_BNE) ? 3'b001 : 3'b000,
                           imm[4:1], imm[11], 7'b1100011};
                end
                K_JAL: begin
                    imm = word_t'(fwd_words(i) * 4);
                    enc = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
                end
                default: enc = EBREAK;
            endcase
            imem[i]  = enc;
            kind[i]  = sel;
            f_rd[i]  = rd;
            f_rs1[i] = rs1;
            f_rs2[i] = rs2;
            f_imm[i] = imm;
        end
        imem[NUM_INSTS]  = EBREAK;
        kind[NUM_INSTS]  = K_HALT;
        f_rd[NUM_INSTS]  = '0;
        f_rs1[NUM_INSTS] = '0;
        f_rs2[NUM_INSTS] = '0;
        f_imm[NUM_INSTS] = '0;
    endtask

    // Instruction-set model that fills the expected retire and store queues
    task automatic run_model();
        int    pc_idx;
        int    next_idx;
        int    jump;
        word_t a, b, res;
        logic  wr;
        logic  done;
        for (int i = 0; i < 32; i++) begin
            mdl_rf[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mdl_mem[i] = fill_word(i);
        end
        pc_idx = 0;
        done = 1'b0;
        while (!done) begin
            a = mdl_rf[f_rs1[pc_idx]];
            b = mdl_rf[f_rs2[pc_idx]];
            res = '0;
            next_idx = pc_idx + 1;
            jump = int'(f_imm[pc_idx] >> 2);
            wr = (kind[pc_idx] <= K_LW) || (kind[pc_idx] == K_JAL);
            case (kind[pc_idx])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_ADDI: res = a + f_imm[pc_idx];
                K_LUI:  res = f_imm[pc_idx];
                K_LW:   res = mdl_mem[f_imm[pc_idx][7:2]];
                K_SW: begin
                    mdl_mem[f_imm[pc_idx][7:2]] = b;
                    exp_st_addr.push_back(f_imm[pc_idx]);
                    exp_st_data.push_back(b);
                end
                K_BEQ: if (a == b) next_idx = pc_idx + jump;
                K_BNE: if (a != b) next_idx = pc_idx + jump;
                K_JAL: begin
                    res = word_t'(next_idx * 4);
                    next_idx = pc_idx + jump;
                end
                default: done = 1'b1;
            endcase
            if (wr && f_rd[pc_idx] != 5'd0) begin
                mdl_rf[f_rd[pc_idx]] = res;
                exp_rd.push_back(f_rd[pc_idx]);
                exp_data.push_back(res);
            end else begin
                exp_rd.push_back(5'd0);
                exp_data.push_back(32'd0);
            end
            exp_pc.push_back(word_t'(pc_idx * 4));
            pc_idx = next_idx;
        end
    endtask

    task automatic check_store();
        word_t addr_e;
        word_t data_e;
        assert (exp_st_addr.size() > 0)
        else abort_run("Data memory write that the model does not predict");
        addr_e = exp_st_addr.pop_front();
        data_e = exp_st_data.pop_front();
        assert (dmem_addr == addr_e && dmem_wdata == data_e)
        else abort_run($sformatf("Mismatch at %0t: store addr %h data %h, expected %h %h",
                                 $time, dmem_addr, dmem_wdata, addr_e, data_e));
    endtask

    task automatic check_retire();
        int        want_cycle;
        word_t     pc_e;
        reg_addr_t rd_e;
        word_t     data_e;
        want_cycle = (retire_cnt == 0) ? RESET_CYCLES + 5 : last_retire + 5;
        assert (cycle_cnt == want_cycle)
        else abort_run($sformatf("Mismatch at %0t: retire in cycle %0d, expected cycle %0d",
                                 $time, cycle_cnt, want_cycle));
        assert (exp_pc.size() > 0)
        else abort_run("Retirement seen after the reference model halted");
        pc_e   = exp_pc.pop_front();
        rd_e   = exp_rd.pop_front();
        data_e = exp_data.pop_front();
        // The fetch address still holds the retiring pc in WB
        assert (retire_pc == pc_e && imem_addr == pc_e
                && retire_rd == rd_e && retire_data == data_e)
        else abort_run($sformatf({"Mismatch at %0t: retire pc %h fetch addr %h rd %0d ",
                                  "data %h, expected pc %h rd %0d data %h"}, $time,
                                 retire_pc, imem_addr, retire_rd, retire_data,
                                 pc_e, rd_e, data_e));
        last_retire = cycle_cnt;
        retire_cnt++;
    endtask

    // Memories answer one cycle after the address
    always @(posedge clk) begin
        imem_data  <= imem[imem_addr[9:2]];
        dmem_rdata <= dmem[dmem_addr[7:2]];
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        assert (cycle_cnt <= MAX_CYCLES)
        else abort_run($sformatf("Timeout, core did not halt within %0d cycles", MAX_CYCLES));
        if (cycle_cnt == RESET_CYCLES + 1) begin
            assert (!retire && !dmem_we && !halted)
            else abort_run($sformatf({"Mismatch at %0t: retire %b dmem_we %b halted %b ",
                                      "after reset, expected all low"}, $time,
                                     retire, dmem_we, halted));
        end
        if (cycle_cnt > RESET_CYCLES && dmem_we) begin
            check_store();
        end
        if (cycle_cnt > RESET_CYCLES && retire) begin
            check_retire();
        end
    end

    initial begin
        rng_state = SEED;
        rst_n = 1'b0;
        build_program();
        run_model();
        model_count = exp_pc.size();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait (halted === 1'b1);
        // Halt must hold for the following cycles
        repeat (10) begin
            @(posedge clk);
            assert (halted === 1'b1)
            else abort_run($sformatf("Mismatch at %0t: halted_o dropped after EBREAK",
                                     $time));
        end
        assert (retire_cnt == model_count)
        else abort_run($sformatf("Mismatch at %0t: %0d retirements, model has %0d",
                                 $time, retire_cnt, model_count));
        assert (exp_st_addr.size() == 0)
        else abort_run("Stores predicted by the model never reached data memory");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: sim.f
core_pkg.sv
core_regfile.sv
core_ifu.sv
core_idu.sv
core_exu.sv
core_wbu.sv
core_top.sv
tb_clk_gen.sv
tb_core_assert.sv
tb_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide pass or fail from the log
rm -rf obj_dir sim.log && \
verilator --binary --timing --assert --top-module tb_core -f sim.f -o tb_core_sim && \
./obj_dir/tb_core_sim 2>&1 | tee sim.log
grep -q "^Simulation completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
